//--- compile.f
hw/rx_pkg.sv
hw/disc_pkg.sv
hw/disc_config_regs.sv
hw/hysteresis_trigger.sv
hw/keep_window.sv
hw/segment_tagger.sv
hw/sample_discriminator.sv
tests/sample_discriminator_tb.sv
tests/tb_top.sv

//--- hw/disc_config_regs.sv
// ==================================================
// configuration register file
// thresholds, delays, trigger sources, disable mask
// ==================================================

module disc_config_regs import rx_pkg::*, disc_pkg::*; (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  logic                  cfg_valid_i,
  output logic                  cfg_ready_o,
  input  cfg_addr_t             cfg_addr_i,
  input  cfg_chan_t             cfg_chan_i,
  input  cfg_data_t             cfg_data_i,
  output sample_t [CHANNELS-1:0] low_thresh_o,
  output sample_t [CHANNELS-1:0] high_thresh_o,
  output delay_t  [CHANNELS-1:0] start_delay_o,
  output delay_t  [CHANNELS-1:0] stop_delay_o,
  output source_t [CHANNELS-1:0] source_o,
  output logic    [CHANNELS-1:0] disable_o
);

  logic cfg_write;

  assign cfg_write = cfg_valid_i & cfg_ready_o;

  // ready rises one cycle after reset is released
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      cfg_ready_o <= 1'b0;
    end else begin
      cfg_ready_o <= 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      low_thresh_o  <= '0;
      high_thresh_o <= '0;
      start_delay_o <= '0;
      stop_delay_o  <= '0;
      disable_o     <= '0;
      // every channel triggers on itself by default
      for (int ch = 0; ch < CHANNELS; ch++) begin
        source_o[ch] <= source_t'(ch);
      end
    end else if (cfg_write) begin
      if (cfg_addr_i == CFG_DISABLE) begin
        disable_o <= cfg_data_i[CHANNELS-1:0];
      end
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (cfg_chan_i == cfg_chan_t'(ch)) begin
          case (cfg_addr_i)
            CFG_THRESH: begin
              high_thresh_o[ch] <= sample_t'(cfg_data_i[2*SAMPLE_WIDTH-1:SAMPLE_WIDTH]);
              low_thresh_o[ch]  <= sample_t'(cfg_data_i[SAMPLE_WIDTH-1:0]);
            end
            CFG_DELAY: begin
              start_delay_o[ch] <= cfg_data_i[TIMER_BITS-1:0];
              stop_delay_o[ch]  <= cfg_data_i[2*TIMER_BITS-1:TIMER_BITS];
            end
            CFG_SOURCE: begin
              source_o[ch] <= cfg_data_i[SOURCE_BITS-1:0];
            end
            default: begin
            end
          endcase
        end
      end
    end
  end

  // host must only address channels that exist
  a_chan_in_range: assert property (
    @(posedge adc_clk) disable iff (reset_i)
    cfg_write |-> (cfg_chan_i < cfg_chan_t'(CHANNELS))
  );

endmodule

//--- hw/disc_pkg.sv
// ==================================================
// discriminator definitions
// delay, source and timestamp widths
// configuration address map
// ==================================================

package disc_pkg;

  // depth of the data delay line
  localparam int MAX_DELAY_CYCLES = 16;
  localparam int TIMER_BITS = $clog2(MAX_DELAY_CYCLES);

  // flag line covers start and stop windows
  localparam int FLAG_LINE_DEPTH = 2 * MAX_DELAY_CYCLES;

  // flag position of the batch being decided
  localparam int WINDOW_CENTER = MAX_DELAY_CYCLES - 1;

  // input to output latency in cycles
  localparam int PIPE_DEPTH = MAX_DELAY_CYCLES + 2;

  // analog sources first, then digital triggers
  localparam int SOURCE_BITS = $clog2(rx_pkg::CHANNELS + rx_pkg::DIGITAL_CHANNELS);

  localparam int TIME_WIDTH = 24;
  localparam int SAMPLE_INDEX_WIDTH = 8;
  localparam int TSTAMP_WIDTH = TIME_WIDTH + SAMPLE_INDEX_WIDTH;

  localparam int CFG_DATA_WIDTH = 32;
  localparam int CFG_CHAN_BITS = 4;

  typedef logic [TIMER_BITS-1:0] delay_t;
  typedef logic [SOURCE_BITS-1:0] source_t;
  typedef logic [TIME_WIDTH-1:0] time_t;
  typedef logic [SAMPLE_INDEX_WIDTH-1:0] index_t;
  typedef logic [TSTAMP_WIDTH-1:0] tstamp_t;
  typedef logic [CFG_DATA_WIDTH-1:0] cfg_data_t;
  typedef logic [CFG_CHAN_BITS-1:0] cfg_chan_t;

  // thresh: high in 31:16, low in 15:0
  // delay: start in 3:0, stop in 7:4
  // disable: whole mask in the low bits, channel ignored
  typedef enum logic [1:0] {
    CFG_THRESH,
    CFG_DELAY,
    CFG_SOURCE,
    CFG_DISABLE
  } cfg_addr_t;

endpackage

//--- hw/hysteresis_trigger.sv
// ==================================================
// hysteresis trigger per analog channel
// trigger source selection and input register
// ==================================================

module hysteresis_trigger import rx_pkg::*, disc_pkg::*; (
  input  logic                          adc_clk,
  input  logic                          reset_i,
  input  logic                          adc_valid_i,
  input  batch_t  [CHANNELS-1:0]        adc_data_i,
  input  logic    [DIGITAL_CHANNELS-1:0] trig_i,
  input  sample_t [CHANNELS-1:0]        low_thresh_i,
  input  sample_t [CHANNELS-1:0]        high_thresh_i,
  input  source_t [CHANNELS-1:0]        source_i,
  output logic    [CHANNELS-1:0]        flag_o,
  output batch_t  [CHANNELS-1:0]        data_o,
  output logic                          valid_o
);

  logic [CHANNELS-1:0] above_high;
  logic [CHANNELS-1:0] above_low;
  logic [CHANNELS-1:0] state_q;
  logic [CHANNELS-1:0] state_d;
  logic [CHANNELS-1:0] flag_d;

  // threshold compare over all samples of the batch
  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      above_high[ch] = 1'b0;
      above_low[ch]  = 1'b0;
      for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
        if (sample_t'(adc_data_i[ch][s*SAMPLE_WIDTH +: SAMPLE_WIDTH]) > high_thresh_i[ch]) begin
          above_high[ch] = 1'b1;
        end
        if (sample_t'(adc_data_i[ch][s*SAMPLE_WIDTH +: SAMPLE_WIDTH]) > low_thresh_i[ch]) begin
          above_low[ch] = 1'b1;
        end
      end
    end
  end

  // clear has priority over set
  always_comb begin
    state_d = state_q;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (adc_valid_i) begin
        if (!above_low[ch]) begin
          state_d[ch] = 1'b0;
        end else if (above_high[ch]) begin
          state_d[ch] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      flag_d[ch] = 1'b0;
      for (int a = 0; a < CHANNELS; a++) begin
        if (source_i[ch] == source_t'(a)) begin
          flag_d[ch] = state_d[a];
        end
      end
      // digital triggers follow the analog sources
      for (int d = 0; d < DIGITAL_CHANNELS; d++) begin
        if (source_i[ch] == source_t'(CHANNELS + d)) begin
          flag_d[ch] = trig_i[d];
        end
      end
      flag_d[ch] = flag_d[ch] & adc_valid_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      state_q <= '0;
      flag_o  <= '0;
      valid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      flag_o  <= flag_d;
      valid_o <= adc_valid_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    data_o <= adc_data_i;
  end

endmodule

//--- hw/keep_window.sv
// ==================================================
// data and flag delay lines
// start/stop window keep decision
// ==================================================

module keep_window import rx_pkg::*, disc_pkg::*; (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  logic   [CHANNELS-1:0] flag_i,
  input  batch_t [CHANNELS-1:0] data_i,
  input  logic                  valid_i,
  input  delay_t [CHANNELS-1:0] start_delay_i,
  input  delay_t [CHANNELS-1:0] stop_delay_i,
  input  logic   [CHANNELS-1:0] disable_i,
  output batch_t [CHANNELS-1:0] data_o,
  output logic                  valid_o,
  output logic   [CHANNELS-1:0] keep_o
);

  batch_t [CHANNELS-1:0] data_q [MAX_DELAY_CYCLES];
  logic [MAX_DELAY_CYCLES-1:0] valid_q;
  logic [CHANNELS-1:0] flag_q [FLAG_LINE_DEPTH];
  logic [CHANNELS-1:0] hit;

  always_ff @(posedge adc_clk) begin
    data_q[0] <= data_i;
    for (int i = 1; i < MAX_DELAY_CYCLES; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      valid_q <= '0;
      for (int i = 0; i < FLAG_LINE_DEPTH; i++) begin
        flag_q[i] <= '0;
      end
    end else begin
      valid_q   <= {valid_q[MAX_DELAY_CYCLES-2:0], valid_i};
      flag_q[0] <= flag_i;
      for (int i = 1; i < FLAG_LINE_DEPTH; i++) begin
        flag_q[i] <= flag_q[i-1];
      end
    end
  end

  // position p counts back from the newest flag, flag_i is p = 0
  // the batch being decided sits at WINDOW_CENTER
  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      hit[ch] = 1'b0;
      if (int'(start_delay_i[ch]) >= WINDOW_CENTER) begin
        hit[ch] = flag_i[ch];
      end
      for (int p = 1; p <= FLAG_LINE_DEPTH; p++) begin
        if ((p + int'(start_delay_i[ch]) >= WINDOW_CENTER) &&
            (p <= WINDOW_CENTER + int'(stop_delay_i[ch]))) begin
          hit[ch] = hit[ch] | flag_q[p-1][ch];
        end
      end
    end
  end

  // valid of the centre batch is one stage before the output tap
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      keep_o <= '0;
    end else begin
      keep_o <= {CHANNELS{valid_q[MAX_DELAY_CYCLES-2]}} & (disable_i | hit);
    end
  end

  assign data_o  = data_q[MAX_DELAY_CYCLES-1];
  assign valid_o = valid_q[MAX_DELAY_CYCLES-1];

  // flags only ever arrive with a valid batch
  a_flag_has_valid: assert property (
    @(posedge adc_clk) disable iff (reset_i)
    (|flag_i) |-> valid_i
  );

endmodule

//--- hw/rx_pkg.sv
// ==================================================
// ADC data path definitions
// channel counts, sample and batch types
// ==================================================

package rx_pkg;

  // analog channels coming from the ADC
  localparam int CHANNELS = 2;

  // digital trigger inputs
  localparam int DIGITAL_CHANNELS = 2;

  localparam int SAMPLE_WIDTH = 16;

  // samples delivered per valid cycle
  localparam int PARALLEL_SAMPLES = 2;

  localparam int BATCH_WIDTH = PARALLEL_SAMPLES * SAMPLE_WIDTH;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // sample 0 sits in the low bits
  typedef logic [BATCH_WIDTH-1:0] batch_t;

endpackage

//--- hw/sample_discriminator.sv
// ==================================================
// multichannel sample discriminator top level
// ==================================================

module sample_discriminator import rx_pkg::*, disc_pkg::*; (
  input  logic                          adc_clk,
  input  logic                          reset_i,
  input  logic                          cfg_valid_i,
  output logic                          cfg_ready_o,
  input  cfg_addr_t                     cfg_addr_i,
  input  cfg_chan_t                     cfg_chan_i,
  input  cfg_data_t                     cfg_data_i,
  input  logic                          adc_valid_i,
  input  batch_t  [CHANNELS-1:0]        adc_data_i,
  input  logic    [DIGITAL_CHANNELS-1:0] trig_i,
  output logic    [CHANNELS-1:0]        data_valid_o,
  output batch_t  [CHANNELS-1:0]        data_o,
  output logic    [CHANNELS-1:0]        tstamp_valid_o,
  output tstamp_t [CHANNELS-1:0]        tstamp_o
);

  sample_t [CHANNELS-1:0] low_thresh;
  sample_t [CHANNELS-1:0] high_thresh;
  delay_t  [CHANNELS-1:0] start_delay;
  delay_t  [CHANNELS-1:0] stop_delay;
  source_t [CHANNELS-1:0] source;
  logic    [CHANNELS-1:0] disable_mask;

  logic    [CHANNELS-1:0] trig_flag;
  batch_t  [CHANNELS-1:0] trig_data;
  logic                   trig_valid;

  batch_t  [CHANNELS-1:0] win_data;
  logic                   win_valid;
  logic    [CHANNELS-1:0] win_keep;

  disc_config_regs i_disc_config_regs (
    .adc_clk       (adc_clk),
    .reset_i       (reset_i),
    .cfg_valid_i   (cfg_valid_i),
    .cfg_ready_o   (cfg_ready_o),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_chan_i    (cfg_chan_i),
    .cfg_data_i    (cfg_data_i),
    .low_thresh_o  (low_thresh),
    .high_thresh_o (high_thresh),
    .start_delay_o (start_delay),
    .stop_delay_o  (stop_delay),
    .source_o      (source),
    .disable_o     (disable_mask)
  );

  hysteresis_trigger i_hysteresis_trigger (
    .adc_clk       (adc_clk),
    .reset_i       (reset_i),
    .adc_valid_i   (adc_valid_i),
    .adc_data_i    (adc_data_i),
    .trig_i        (trig_i),
    .low_thresh_i  (low_thresh),
    .high_thresh_i (high_thresh),
    .source_i      (source),
    .flag_o        (trig_flag),
    .data_o        (trig_data),
    .valid_o       (trig_valid)
  );

  keep_window i_keep_window (
    .adc_clk       (adc_clk),
    .reset_i       (reset_i),
    .flag_i        (trig_flag),
    .data_i        (trig_data),
    .valid_i       (trig_valid),
    .start_delay_i (start_delay),
    .stop_delay_i  (stop_delay),
    .disable_i     (disable_mask),
    .data_o        (win_data),
    .valid_o       (win_valid),
    .keep_o        (win_keep)
  );

  segment_tagger i_segment_tagger (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .data_i         (win_data),
    .valid_i        (win_valid),
    .keep_i         (win_keep),
    .data_valid_o   (data_valid_o),
    .data_o         (data_o),
    .tstamp_valid_o (tstamp_valid_o),
    .tstamp_o       (tstamp_o)
  );

endmodule

//--- hw/segment_tagger.sv
// ==================================================
// output stage with segment timestamps
// cycle counter and per-channel kept index
// ==================================================

module segment_tagger import rx_pkg::*, disc_pkg::*; (
  input  logic                   adc_clk,
  input  logic                   reset_i,
  input  batch_t  [CHANNELS-1:0] data_i,
  input  logic                   valid_i,
  input  logic    [CHANNELS-1:0] keep_i,
  output logic    [CHANNELS-1:0] data_valid_o,
  output batch_t  [CHANNELS-1:0] data_o,
  output logic    [CHANNELS-1:0] tstamp_valid_o,
  output tstamp_t [CHANNELS-1:0] tstamp_o
);

  time_t cycle_count;
  index_t [CHANNELS-1:0] kept_index;
  logic [CHANNELS-1:0] prev_kept;
  logic [CHANNELS-1:0] seg_start;

  // first kept batch after a dropped valid batch
  assign seg_start = {CHANNELS{valid_i}} & keep_i & ~prev_kept;

  // counter lags the input by the pipeline so it reads as input time
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      cycle_count <= time_t'(0) - time_t'(PIPE_DEPTH - 1);
    end else begin
      cycle_count <= cycle_count + time_t'(1);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      kept_index <= '0;
      prev_kept  <= '0;
    end else if (valid_i) begin
      prev_kept <= keep_i;
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (keep_i[ch]) begin
          kept_index[ch] <= kept_index[ch] + index_t'(1);
        end
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      data_valid_o   <= '0;
      tstamp_valid_o <= '0;
    end else begin
      data_valid_o   <= {CHANNELS{valid_i}} & keep_i;
      tstamp_valid_o <= seg_start;
    end
  end

  // time in the high bits, index below
  always_ff @(posedge adc_clk) begin
    data_o <= data_i;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      tstamp_o[ch] <= {cycle_count, kept_index[ch]};
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build the discriminator testbench with Verilator and run it
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f compile.f --top-module tb_top -o tb_top \
  && ./obj_dir/tb_top \
  || exit 1

//--- tests/sample_discriminator_tb.sv
// ==================================================
// testbench utility for the sample discriminator
// config writes, random stream, reference model
// compare tasks
// ==================================================

module sample_discriminator_tb import rx_pkg::*, disc_pkg::*; (
  input  logic                           adc_clk,
  input  logic                           reset_i,
  output logic                           cfg_valid_o,
  input  logic                           cfg_ready_i,
  output cfg_addr_t                      cfg_addr_o,
  output cfg_chan_t                      cfg_chan_o,
  output cfg_data_t                      cfg_data_o,
  output logic                           adc_valid_o,
  output batch_t  [CHANNELS-1:0]         adc_data_o,
  output logic    [DIGITAL_CHANNELS-1:0] trig_o,
  input  logic    [CHANNELS-1:0]         data_valid_i,
  input  batch_t  [CHANNELS-1:0]         data_i,
  input  logic    [CHANNELS-1:0]         tstamp_valid_i,
  input  tstamp_t [CHANNELS-1:0]         tstamp_i,
  output logic                           error_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HIST = 64;
  localparam int CFG_TIMEOUT = 50;

  integer seed = 32'hc19e_a771;

  // model copy of the configuration
  sample_t [CHANNELS-1:0] m_low;
  sample_t [CHANNELS-1:0] m_high;
  delay_t  [CHANNELS-1:0] m_start;
  delay_t  [CHANNELS-1:0] m_stop;
  source_t [CHANNELS-1:0] m_src;
  logic    [CHANNELS-1:0] m_dis;

  int cyc;
  logic reset_seen = 1'b0;
  logic ready_seen;
  logic [CHANNELS-1:0] hyst;
  index_t [CHANNELS-1:0] kept_idx;
  logic [CHANNELS-1:0] prev_kept;

  // input history and expected outputs, indexed by input cycle
  logic hist_valid [HIST];
  batch_t [CHANNELS-1:0] hist_data [HIST];
  logic [CHANNELS-1:0] hist_flag [HIST];
  logic [CHANNELS-1:0] exp_dvalid [HIST];
  logic [CHANNELS-1:0] exp_tvalid [HIST];
  batch_t [CHANNELS-1:0] exp_data [HIST];
  tstamp_t [CHANNELS-1:0] exp_tstamp [HIST];

  logic mismatch_seen = 1'b0;
  logic timeout_seen = 1'b0;

  assign error_o = mismatch_seen | timeout_seen;

  task automatic check_flag(string name, logic got, logic exp);
    if (!mismatch_seen && got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
      mismatch_seen = 1'b1;
    end
  endtask

  task automatic check_bits(string name, logic [CHANNELS-1:0] got, logic [CHANNELS-1:0] exp);
    if (!mismatch_seen && got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
      mismatch_seen = 1'b1;
    end
  endtask

  task automatic check_batch(string name, batch_t got, batch_t exp);
    if (!mismatch_seen && got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      mismatch_seen = 1'b1;
    end
  endtask

  task automatic check_tstamp(string name, tstamp_t got, tstamp_t exp);
    if (!mismatch_seen && got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      mismatch_seen = 1'b1;
    end
  endtask

  task automatic init_inputs();
    cfg_valid_o = 1'b0;
    cfg_addr_o  = CFG_THRESH;
    cfg_chan_o  = '0;
    cfg_data_o  = '0;
    adc_valid_o = 1'b0;
    adc_data_o  = '0;
    trig_o      = '0;
  endtask

  task automatic write_cfg(cfg_addr_t addr, int chan, cfg_data_t data);
    int waited;
    @(negedge adc_clk);
    cfg_addr_o  = addr;
    cfg_chan_o  = cfg_chan_t'(chan);
    cfg_data_o  = data;
    cfg_valid_o = 1'b1;
    waited = 0;
    while (!cfg_ready_i && !timeout_seen) begin
      @(negedge adc_clk);
      waited++;
      if (waited > CFG_TIMEOUT) begin
        $display("ERROR time=%0t configuration port never became ready", $time);
        timeout_seen = 1'b1;
      end
    end
    // ready seen with valid high, so the write lands on the next edge
    @(negedge adc_clk);
    cfg_valid_o = 1'b0;
  endtask

  task automatic set_thresh(int ch, int low, int high);
    write_cfg(CFG_THRESH, ch, {sample_t'(high), sample_t'(low)});
  endtask

  task automatic set_delays(int ch, int start, int stop);
    write_cfg(CFG_DELAY, ch, cfg_data_t'({delay_t'(stop), delay_t'(start)}));
  endtask

  task automatic set_source(int ch, int src);
    write_cfg(CFG_SOURCE, ch, cfg_data_t'(source_t'(src)));
  endtask

  task automatic set_disable(logic [CHANNELS-1:0] mask);
    write_cfg(CFG_DISABLE, 0, cfg_data_t'(mask));
  endtask

  task automatic randomize_delays();
    for (int ch = 0; ch < CHANNELS; ch++) begin
      set_delays(ch, $random(seed) & 15, $random(seed) & 15);
    end
  endtask

  task automatic run_stream(int cycles, int valid_pct);
    for (int n = 0; n < cycles; n++) begin
      @(negedge adc_clk);
      adc_valid_o = ((($random(seed) & 32'h7fff_ffff) % 100) < valid_pct);
      for (int ch = 0; ch < CHANNELS; ch++) begin
        for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
          adc_data_o[ch][s*SAMPLE_WIDTH +: SAMPLE_WIDTH] = sample_t'($random(seed) % 12000);
        end
      end
      // sparse digital triggers
      for (int d = 0; d < DIGITAL_CHANNELS; d++) begin
        trig_o[d] = (($random(seed) & 15) == 0);
      end
    end
  endtask

  task automatic hold_idle(int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge adc_clk);
      adc_valid_o = 1'b0;
      trig_o      = '0;
    end
  endtask

  function automatic logic next_state(logic cur, batch_t b, sample_t lo, sample_t hi);
    logic any_high;
    logic any_low;
    sample_t s;
    any_high = 1'b0;
    any_low  = 1'b0;
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      s = b[i*SAMPLE_WIDTH +: SAMPLE_WIDTH];
      any_high |= (s > hi);
      any_low  |= (s > lo);
    end
    // clear beats set
    if (!any_low) begin
      return 1'b0;
    end else if (any_high) begin
      return 1'b1;
    end else begin
      return cur;
    end
  endfunction

  function automatic logic in_window(int t, int ch);
    logic hit;
    hit = 1'b0;
    for (int u = t - int'(m_stop[ch]); u <= t + int'(m_start[ch]); u++) begin
      hit |= hist_flag[u & (HIST-1)][ch];
    end
    return hit;
  endfunction

  task automatic record_input();
    int k;
    logic [CHANNELS-1:0] flag;
    k = cyc & (HIST-1);
    if (adc_valid_o) begin
      for (int a = 0; a < CHANNELS; a++) begin
        hyst[a] = next_state(hyst[a], adc_data_o[a], m_low[a], m_high[a]);
      end
    end
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (int'(m_src[ch]) < CHANNELS) begin
        flag[ch] = hyst[int'(m_src[ch])];
      end else begin
        flag[ch] = trig_o[int'(m_src[ch]) - CHANNELS];
      end
    end
    hist_valid[k] = adc_valid_o;
    hist_data[k]  = adc_data_o;
    hist_flag[k]  = flag & {CHANNELS{adc_valid_o}};
  endtask

  task automatic apply_write();
    int ch;
    ch = int'(cfg_chan_o);
    case (cfg_addr_o)
      CFG_THRESH: begin
        m_high[ch] = cfg_data_o[31:16];
        m_low[ch]  = cfg_data_o[15:0];
      end
      CFG_DELAY: begin
        m_start[ch] = cfg_data_o[3:0];
        m_stop[ch]  = cfg_data_o[7:4];
      end
      CFG_SOURCE: begin
        m_src[ch] = cfg_data_o[1:0];
      end
      default: begin
        m_dis = cfg_data_o[CHANNELS-1:0];
      end
    endcase
  endtask

  task automatic decide_batch(int t);
    int k;
    logic keep;
    k = t & (HIST-1);
    for (int ch = 0; ch < CHANNELS; ch++) begin
      keep = hist_valid[k] & (m_dis[ch] | in_window(t, ch));
      exp_dvalid[k][ch] = keep;
      exp_tvalid[k][ch] = keep & ~prev_kept[ch];
      exp_data[k][ch]   = hist_data[k][ch];
      exp_tstamp[k][ch] = {time_t'(t), kept_idx[ch]};
      if (hist_valid[k]) begin
        prev_kept[ch] = keep;
        if (keep) begin
          kept_idx[ch] = kept_idx[ch] + index_t'(1);
        end
      end
    end
  endtask

  always @(posedge adc_clk) begin
    if (reset_i) begin
      reset_seen = 1'b1;
      cyc        = 0;
      hyst       = '0;
      kept_idx   = '0;
      prev_kept  = '0;
      m_low      = '0;
      m_high     = '0;
      m_start    = '0;
      m_stop     = '0;
      m_dis      = '0;
      for (int ch = 0; ch < CHANNELS; ch++) begin
        m_src[ch] = source_t'(ch);
      end
      for (int i = 0; i < HIST; i++) begin
        hist_valid[i] = 1'b0;
        hist_flag[i]  = '0;
        exp_dvalid[i] = '0;
        exp_tvalid[i] = '0;
      end
    end else begin
      record_input();
      if (cfg_valid_o && ready_seen) begin
        apply_write();
      end
      // all flags up to t+15 are known by now
      decide_batch(cyc - (MAX_DELAY_CYCLES - 1));
      cyc = cyc + 1;
    end
  end

  always @(negedge adc_clk) begin
    int k;
    ready_seen = cfg_ready_i;
    if (reset_seen) begin
      k = (cyc - PIPE_DEPTH) & (HIST-1);
      check_flag("cfg_ready_o", cfg_ready_i, cyc >= 1);
      check_bits("data_valid_o", data_valid_i, exp_dvalid[k]);
      check_bits("tstamp_valid_o", tstamp_valid_i, exp_tvalid[k]);
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (exp_dvalid[k][ch]) begin
          check_batch($sformatf("data_o[%0d]", ch), data_i[ch], exp_data[k][ch]);
        end
        if (exp_tvalid[k][ch]) begin
          check_tstamp($sformatf("tstamp_o[%0d]", ch), tstamp_i[ch], exp_tstamp[k][ch]);
        end
      end
    end
  end

endmodule

//--- tests/tb_top.sv
// ==================================================
// testbench top with clock, reset, DUT
// and the test sequence
// ==================================================

module tb_top import rx_pkg::*, disc_pkg::*;;

  timeunit 1ns;
  timeprecision 1ps;

  logic                          adc_clk = 1'b0;
  logic                          reset_i;
  logic                          cfg_valid;
  logic                          cfg_ready;
  cfg_addr_t                     cfg_addr;
  cfg_chan_t                     cfg_chan;
  cfg_data_t                     cfg_data;
  logic                          adc_valid;
  batch_t  [CHANNELS-1:0]        adc_data;
  logic    [DIGITAL_CHANNELS-1:0] trig;
  logic    [CHANNELS-1:0]        data_valid;
  batch_t  [CHANNELS-1:0]        data;
  logic    [CHANNELS-1:0]        tstamp_valid;
  tstamp_t [CHANNELS-1:0]        tstamp;
  logic                          tb_error;

  always #5 adc_clk = ~adc_clk;

  sample_discriminator i_sample_discriminator (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .cfg_valid_i    (cfg_valid),
    .cfg_ready_o    (cfg_ready),
    .cfg_addr_i     (cfg_addr),
    .cfg_chan_i     (cfg_chan),
    .cfg_data_i     (cfg_data),
    .adc_valid_i    (adc_valid),
    .adc_data_i     (adc_data),
    .trig_i         (trig),
    .data_valid_o   (data_valid),
    .data_o         (data),
    .tstamp_valid_o (tstamp_valid),
    .tstamp_o       (tstamp)
  );

  sample_discriminator_tb u_tb (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .cfg_valid_o    (cfg_valid),
    .cfg_ready_i    (cfg_ready),
    .cfg_addr_o     (cfg_addr),
    .cfg_chan_o     (cfg_chan),
    .cfg_data_o     (cfg_data),
    .adc_valid_o    (adc_valid),
    .adc_data_o     (adc_data),
    .trig_o         (trig),
    .data_valid_i   (data_valid),
    .data_i         (data),
    .tstamp_valid_i (tstamp_valid),
    .tstamp_i       (tstamp),
    .error_o        (tb_error)
  );

  always @(posedge tb_error) begin
    $display("RESULT: FAIL");
    $fatal(1, "testbench check failed");
  end

  initial begin
    reset_i = 1'b1;
    u_tb.init_inputs();
    repeat (5) @(posedge adc_clk);
    @(negedge adc_clk);
    reset_i = 1'b0;

    // hysteresis with zero delays, ch1 thresholds inverted
    u_tb.set_thresh(0, -1000, 6000);
    u_tb.set_thresh(1, 4000, -3000);
    u_tb.run_stream(300, 100);
    u_tb.run_stream(300, 60);

    // random start and stop windows under decimation
    u_tb.hold_idle(20);
    u_tb.set_thresh(1, 2000, 9000);
    u_tb.randomize_delays();
    u_tb.run_stream(400, 50);

    // cross-channel and digital trigger sources
    u_tb.set_source(0, 1);
    u_tb.set_source(1, CHANNELS);
    u_tb.run_stream(300, 70);
    u_tb.set_source(0, CHANNELS + 1);
    u_tb.set_source(1, 0);
    u_tb.run_stream(300, 70);

    // disabled channels pass everything
    u_tb.hold_idle(20);
    u_tb.set_disable(2'b01);
    u_tb.run_stream(200, 40);
    u_tb.hold_idle(20);
    u_tb.set_disable(2'b11);
    u_tb.run_stream(200, 40);
    u_tb.hold_idle(20);
    u_tb.set_disable(2'b00);
    u_tb.set_source(0, 0);
    u_tb.set_source(1, 1);

    // reconfigure while samples keep arriving
    fork
      u_tb.run_stream(300, 80);
      begin
        repeat (60) @(negedge adc_clk);
        u_tb.set_thresh(0, 3000, 5000);
        repeat (60) @(negedge adc_clk);
        u_tb.set_source(1, CHANNELS);
      end
    join

    // let the pipeline drain
    u_tb.hold_idle(40);
    if (!tb_error) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "testbench check failed");
    end
  end

endmodule
